/* design/stream_pkg.sv */
/*
   Stream package
   Stream widths, FIFO depths, sequencer state codes and the RDMA header word
*/
`default_nettype none

package stream_pkg;

   // Stream width in bytes and in bits
   localparam int STREAM_WB  = 64;
   localparam int DATA_WIDTH = STREAM_WB * 8;

   // FIFO depths in words
   localparam int DATA_FIFO_DEPTH = 32;
   localparam int LEN_FIFO_DEPTH  = 8;

   // Target address plus burst length
   localparam int RDMA_HDR_LEN = 9;

   // Transmit sequencer states
   localparam logic [1:0] SEQ_INIT    = 2'd0;
   localparam logic [1:0] SEQ_HDR     = 2'd1;
   localparam logic [1:0] SEQ_PAYLOAD = 2'd2;

   // Packet length in bytes
   typedef logic [15:0] pkt_len_t;

   // RDMA header word, raw in the FIFO, split into fields in the builder
   typedef union packed {
      logic [RDMA_HDR_LEN*8-1:0] raw;
      struct packed {
         logic [7:0]  burst_len;
         logic [63:0] target_addr;
      } fields;
   } rdma_hdr_u;

endpackage

`default_nettype wire

/* design/net_hdr_pkg.sv */
/*
   Network header package
   Ethernet, IPv4 and UDP header lengths and the fixed field values
   used when framing each RDMA packet
*/
`default_nettype none

package net_hdr_pkg;

   // ==============================
   // Header lengths in bytes
   // ==============================
   localparam int ETH_HDR_LEN = 14;
   localparam int IP_HDR_LEN  = 20;
   localparam int UDP_HDR_LEN = 8;

   // Eth + IPv4 + UDP + RDMA fields, 51 bytes
   localparam int FULL_HDR_LEN = ETH_HDR_LEN + IP_HDR_LEN + UDP_HDR_LEN
                                 + stream_pkg::RDMA_HDR_LEN;

   // ==============================
   // Ethernet fields
   // ==============================
   // Broadcast destination
   localparam logic [47:0] ETH_DST_MAC    = 48'hFFFF_FFFF_FFFF;
   localparam logic [47:0] ETH_SRC_MAC    = 48'hC400_AD00_0002;
   // IPv4 ethertype
   localparam logic [15:0] ETH_FRAME_TYPE = 16'h0800;

   // ==============================
   // IPv4 fields
   // ==============================
   // Version 4, IHL 5, no DSCP
   localparam logic [15:0] IP_VER_DSF   = 16'h4500;
   localparam logic [15:0] IP_ID        = 16'hDEAD;
   // Don't fragment
   localparam logic [15:0] IP_FLAGS     = 16'h4000;
   // TTL 64, protocol UDP
   localparam logic [15:0] IP_TTL_PROT  = 16'h4011;
   // Source 10.1.1.2
   localparam logic [15:0] IP_SRC_HI    = {8'd10, 8'd1};
   localparam logic [15:0] IP_SRC_LO    = {8'd1, 8'd2};
   // Destination 10.1.1.255, subnet broadcast
   localparam logic [15:0] IP_DST_HI    = {8'd10, 8'd1};
   localparam logic [15:0] IP_DST_LO    = {8'd1, 8'd255};

   // ==============================
   // UDP fields
   // ==============================
   localparam logic [15:0] UDP_SRC_PORT = 16'd1000;
   localparam logic [15:0] UDP_DST_PORT = 16'd32002;
   // Checksum unused over IPv4
   localparam logic [15:0] UDP_CHECKSUM = 16'h0000;

endpackage

`default_nettype wire

/* design/axis_beat_if.sv */
/*
   Packet beat interface
   One stream beat with valid/ready, from the data FIFO to the sequencer
*/
`timescale 1ns/100ps
`default_nettype none

interface axis_beat_if
   import stream_pkg::*;
();

   logic [DATA_WIDTH-1:0] tdata;
   logic [STREAM_WB-1:0]  tkeep;
   logic                  tvalid;
   logic                  tlast;
   logic                  tready;

   // FIFO side
   modport source (output tdata, output tkeep, output tvalid, output tlast, input tready);

   // Sequencer side
   modport sink (input tdata, input tkeep, input tvalid, input tlast, output tready);

endinterface

`default_nettype wire

/* design/sync_fifo.sv */
/*
   Synchronous FIFO
   Single-clock ring buffer with a registered first-word output
   Valid/ready on both sides, bypass into the output register when empty
*/
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
   parameter int WIDTH = 16,
   parameter int DEPTH = 8
) (
   input  wire logic             clk,
   input  wire logic             resetn,
   input  wire logic [WIDTH-1:0] wr_data,
   input  wire logic             wr_valid,
   output logic                  wr_ready,
   output logic      [WIDTH-1:0] rd_data,
   output logic                  rd_valid,
   input  wire logic             rd_ready
);

   // Storage, not counting the output register
   logic [WIDTH-1:0]           mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;
   // Low through reset and the first cycle after it
   logic                       running;

   logic push;
   logic pop;
   logic mem_empty;
   logic load_out;
   logic mem_wr;
   logic mem_rd;

   assign push      = wr_valid & wr_ready;
   assign pop       = rd_valid & rd_ready;
   assign mem_empty = (count == 0);
   // Output register is free or being emptied this cycle
   assign load_out  = ~rd_valid | pop;
   // Refill from memory first, keeps word order
   assign mem_rd    = load_out & ~mem_empty;
   // Write goes around the memory when it can land in the output directly
   assign mem_wr    = push & ~(load_out & mem_empty);
   assign wr_ready  = running & (count != DEPTH);

   // Pointers, count and output valid
   always_ff @(posedge clk) begin
      if (!resetn) begin
         running  <= 1'b0;
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         rd_valid <= 1'b0;
      end else begin
         running <= 1'b1;
         if (mem_wr) begin
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (mem_rd) begin
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + mem_wr - mem_rd;
         if (load_out) begin
            rd_valid <= ~mem_empty | push;
         end
      end
   end

   // Data path
   always_ff @(posedge clk) begin
      if (mem_wr) begin
         mem[wr_ptr] <= wr_data;
      end
      if (mem_rd) begin
         rd_data <= mem[rd_ptr];
      end else if (load_out & push) begin
         rd_data <= wr_data;
      end
   end

endmodule

`default_nettype wire

/* design/packet_length_meter.sv */
/*
   Packet length meter
   Counts kept bytes of each accepted beat, reports the packet total on tlast
*/
`timescale 1ns/100ps
`default_nettype none

module packet_length_meter
   import stream_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 resetn,
   input  wire logic [STREAM_WB-1:0] beat_keep,
   input  wire logic                 beat_fire,
   input  wire logic                 beat_last,
   output pkt_len_t                  len_data,
   output logic                      len_valid
);

   // Bytes in earlier beats of this packet
   pkt_len_t acc;
   pkt_len_t beat_bytes;

   // Popcount of tkeep
   always_comb begin
      beat_bytes = '0;
      for (int i = 0; i < STREAM_WB; i++) begin
         beat_bytes = beat_bytes + pkt_len_t'(beat_keep[i]);
      end
   end

   // Total including the current beat, only meaningful on the last one
   assign len_data  = acc + beat_bytes;
   assign len_valid = beat_fire & beat_last;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         acc <= '0;
      end else if (beat_fire) begin
         // Restart on every packet boundary
         acc <= beat_last ? '0 : len_data;
      end
   end

endmodule

`default_nettype wire

/* design/udp_header_builder.sv */
/*
   UDP header builder
   Ethernet/IPv4/UDP/RDMA header for one packet, with lengths and IPv4 checksum
   Output is byte-reversed so the first wire byte sits in lane 0
*/
`timescale 1ns/100ps
`default_nettype none

module udp_header_builder
   import stream_pkg::*;
   import net_hdr_pkg::*;
(
   input  wire pkt_len_t               pkt_len,
   input  wire rdma_hdr_u              rdma_hdr,
   output logic     [DATA_WIDTH-1:0]   hdr_data,
   output logic     [STREAM_WB-1:0]    hdr_keep
);

   logic [15:0]                ip_len;
   logic [15:0]                udp_len;
   logic [31:0]                ip_sum;
   logic [15:0]                ip_fold;
   logic [15:0]                ip_checksum;
   logic [FULL_HDR_LEN*8-1:0]  hdr_be;
   logic [FULL_HDR_LEN*8-1:0]  hdr_le;

   // IPv4 total length covers IP + UDP + RDMA fields + payload
   assign ip_len  = pkt_len_t'(IP_HDR_LEN + UDP_HDR_LEN + RDMA_HDR_LEN) + pkt_len;
   assign udp_len = pkt_len_t'(UDP_HDR_LEN + RDMA_HDR_LEN) + pkt_len;

   // ==============================
   // IPv4 checksum
   // ==============================
   // Checksum field counts as zero in the sum
   assign ip_sum = IP_VER_DSF + ip_len + IP_ID + IP_FLAGS + IP_TTL_PROT
                 + IP_SRC_HI + IP_SRC_LO + IP_DST_HI + IP_DST_LO;
   // Single fold, carry out of the fold is dropped
   assign ip_fold     = ip_sum[15:0] + ip_sum[31:16];
   assign ip_checksum = ~ip_fold;

   // ==============================
   // Header in network order
   // ==============================
   assign hdr_be = {
      // Ethernet
      ETH_DST_MAC, ETH_SRC_MAC, ETH_FRAME_TYPE,
      // IPv4
      IP_VER_DSF, ip_len, IP_ID, IP_FLAGS, IP_TTL_PROT, ip_checksum,
      IP_SRC_HI, IP_SRC_LO, IP_DST_HI, IP_DST_LO,
      // UDP
      UDP_SRC_PORT, UDP_DST_PORT, udp_len, UDP_CHECKSUM,
      // RDMA fields
      rdma_hdr.fields.target_addr, rdma_hdr.fields.burst_len
   };

   // MAC sends lane 0 first
   always_comb begin
      for (int i = 0; i < FULL_HDR_LEN; i++) begin
         hdr_le[i*8 +: 8] = hdr_be[(FULL_HDR_LEN-1-i)*8 +: 8];
      end
   end

   // Upper 13 lanes zero and not kept
   assign hdr_data = DATA_WIDTH'(hdr_le);
   assign hdr_keep = STREAM_WB'({FULL_HDR_LEN{1'b1}});

endmodule

`default_nettype wire

/* design/tx_sequencer.sv */
/*
   Transmit sequencer
   Sends one header beat per packet, then copies the buffered payload beats
   States: init after reset, header, payload
*/
`timescale 1ns/100ps
`default_nettype none

module tx_sequencer
   import stream_pkg::*;
(
   input  wire logic                  clk,
   input  wire logic                  resetn,
   axis_beat_if.sink                  data,
   // Length FIFO output
   input  wire pkt_len_t              len_data,
   input  wire logic                  len_valid,
   output logic                       len_ready,
   // RDMA header FIFO output
   input  wire rdma_hdr_u             rdma_data,
   input  wire logic                  rdma_valid,
   output logic                       rdma_ready,
   // To and from the header builder
   output rdma_hdr_u                  hdr_fields,
   output pkt_len_t                   pkt_len,
   input  wire logic [DATA_WIDTH-1:0] hdr_data,
   input  wire logic [STREAM_WB-1:0]  hdr_keep,
   // Output stream
   output logic      [DATA_WIDTH-1:0] tx_data,
   output logic      [STREAM_WB-1:0]  tx_keep,
   output logic                       tx_valid,
   output logic                       tx_last,
   input  wire logic                  tx_ready
);

   logic [1:0] state;
   // An RDMA header word sits in hdr_reg
   logic       hdr_held;
   rdma_hdr_u  hdr_reg;

   logic in_hdr;
   logic in_payload;
   logic hdr_valid;
   logic hdr_fire;
   logic last_fire;

   assign in_hdr     = (state == SEQ_HDR);
   assign in_payload = (state == SEQ_PAYLOAD);

   // Take a header word only while none is held
   assign rdma_ready = in_hdr & ~hdr_held;

   // Header beat needs a measured packet and its RDMA fields, never ready
   assign hdr_valid  = in_hdr & len_valid & hdr_held;
   assign hdr_fire   = hdr_valid & tx_ready;
   // Length pops together with the header beat
   assign len_ready  = in_hdr & hdr_held & tx_ready;

   assign last_fire  = data.tvalid & data.tready & data.tlast;

   // Builder sees the held fields and the head of the length FIFO
   assign hdr_fields = hdr_reg;
   assign pkt_len    = len_data;

   // ==============================
   // Output select
   // ==============================
   always_comb begin
      tx_data  = '0;
      tx_keep  = '0;
      tx_valid = 1'b0;
      tx_last  = 1'b0;
      if (in_hdr) begin
         tx_data  = hdr_data;
         tx_keep  = hdr_keep;
         tx_valid = hdr_valid;
      end else if (in_payload) begin
         // Straight from the data FIFO
         tx_data  = data.tdata;
         tx_keep  = data.tkeep;
         tx_valid = data.tvalid;
         tx_last  = data.tlast;
      end
   end

   assign data.tready = in_payload & tx_ready;

   // ==============================
   // State machine
   // ==============================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         state    <= SEQ_INIT;
         hdr_held <= 1'b0;
      end else begin
         case (state)
            // One idle cycle out of reset
            SEQ_INIT: state <= SEQ_HDR;
            SEQ_HDR: begin
               if (rdma_valid & rdma_ready) begin
                  hdr_held <= 1'b1;
               end
               if (hdr_fire) begin
                  hdr_held <= 1'b0;
                  state    <= SEQ_PAYLOAD;
               end
            end
            SEQ_PAYLOAD: begin
               if (last_fire) begin
                  state <= SEQ_HDR;
               end
            end
            default: state <= SEQ_INIT;
         endcase
      end
   end

   // Header word capture
   always_ff @(posedge clk) begin
      if (rdma_valid & rdma_ready) begin
         hdr_reg <= rdma_data;
      end
   end

endmodule

`default_nettype wire

/* design/rdma_framer_top.sv */
/*
   RDMA framer top level
   Buffers packets and their lengths, frames each with an Eth/IPv4/UDP/RDMA
   header beat and streams header plus payload out
*/
`timescale 1ns/100ps
`default_nettype none

module rdma_framer_top
   import stream_pkg::*;
(
   input  wire logic                      clk,
   input  wire logic                      resetn,
   // Input packet stream
   input  wire logic [DATA_WIDTH-1:0]     s_data_tdata,
   input  wire logic [STREAM_WB-1:0]      s_data_tkeep,
   input  wire logic                      s_data_tvalid,
   input  wire logic                      s_data_tlast,
   output logic                           s_data_tready,
   // RDMA header channel
   input  wire logic [RDMA_HDR_LEN*8-1:0] s_rdma_tdata,
   input  wire logic                      s_rdma_tvalid,
   output logic                          s_rdma_tready,
   // Framed output stream
   output logic      [DATA_WIDTH-1:0]     m_tx_tdata,
   output logic      [STREAM_WB-1:0]      m_tx_tkeep,
   output logic                          m_tx_tvalid,
   output logic                          m_tx_tlast,
   input  wire logic                      m_tx_tready
);

   // Packet data FIFO, word is {tlast, tkeep, tdata}
   logic                          data_wr_valid;
   logic                          data_wr_ready;
   logic [DATA_WIDTH+STREAM_WB:0] data_rd_word;
   // Length path
   pkt_len_t                      len_wr_data;
   logic                          len_wr_valid;
   logic                          len_wr_ready;
   pkt_len_t                      len_rd_data;
   logic                          len_rd_valid;
   logic                          len_rd_ready;
   // RDMA header FIFO output
   rdma_hdr_u                     rdma_rd_word;
   logic                          rdma_rd_valid;
   logic                          rdma_rd_ready;
   // Builder connections
   rdma_hdr_u                     hdr_fields;
   pkt_len_t                      hdr_pkt_len;
   logic [DATA_WIDTH-1:0]         hdr_data;
   logic [STREAM_WB-1:0]          hdr_keep;

   axis_beat_if beat ();

   // Input also stalls on a full length FIFO so no length is lost
   assign s_data_tready = data_wr_ready & len_wr_ready;
   assign data_wr_valid = s_data_tvalid & len_wr_ready;

   assign {beat.tlast, beat.tkeep, beat.tdata} = data_rd_word;

   // ==============================
   // FIFOs
   // ==============================
   sync_fifo #(.WIDTH(DATA_WIDTH + STREAM_WB + 1), .DEPTH(DATA_FIFO_DEPTH)) data_fifo (
      .clk      (clk),
      .resetn   (resetn),
      .wr_data  ({s_data_tlast, s_data_tkeep, s_data_tdata}),
      .wr_valid (data_wr_valid),
      .wr_ready (data_wr_ready),
      .rd_data  (data_rd_word),
      .rd_valid (beat.tvalid),
      .rd_ready (beat.tready)
   );

   sync_fifo #(.WIDTH($bits(pkt_len_t)), .DEPTH(LEN_FIFO_DEPTH)) len_fifo (
      .clk      (clk),
      .resetn   (resetn),
      .wr_data  (len_wr_data),
      .wr_valid (len_wr_valid),
      .wr_ready (len_wr_ready),
      .rd_data  (len_rd_data),
      .rd_valid (len_rd_valid),
      .rd_ready (len_rd_ready)
   );

   // Raw view on the FIFO side
   sync_fifo #(.WIDTH(RDMA_HDR_LEN * 8), .DEPTH(LEN_FIFO_DEPTH)) rdma_fifo (
      .clk      (clk),
      .resetn   (resetn),
      .wr_data  (s_rdma_tdata),
      .wr_valid (s_rdma_tvalid),
      .wr_ready (s_rdma_tready),
      .rd_data  (rdma_rd_word.raw),
      .rd_valid (rdma_rd_valid),
      .rd_ready (rdma_rd_ready)
   );

   // ==============================
   // Length, header, sequencing
   // ==============================
   packet_length_meter meter (
      .clk       (clk),
      .resetn    (resetn),
      .beat_keep (s_data_tkeep),
      .beat_fire (s_data_tvalid & s_data_tready),
      .beat_last (s_data_tlast),
      .len_data  (len_wr_data),
      .len_valid (len_wr_valid)
   );

   udp_header_builder builder (
      .pkt_len  (hdr_pkt_len),
      .rdma_hdr (hdr_fields),
      .hdr_data (hdr_data),
      .hdr_keep (hdr_keep)
   );

   tx_sequencer sequencer (
      .clk        (clk),
      .resetn     (resetn),
      .data       (beat.sink),
      .len_data   (len_rd_data),
      .len_valid  (len_rd_valid),
      .len_ready  (len_rd_ready),
      .rdma_data  (rdma_rd_word),
      .rdma_valid (rdma_rd_valid),
      .rdma_ready (rdma_rd_ready),
      .hdr_fields (hdr_fields),
      .pkt_len    (hdr_pkt_len),
      .hdr_data   (hdr_data),
      .hdr_keep   (hdr_keep),
      .tx_data    (m_tx_tdata),
      .tx_keep    (m_tx_tkeep),
      .tx_valid   (m_tx_tvalid),
      .tx_last    (m_tx_tlast),
      .tx_ready   (m_tx_tready)
   );

endmodule

`default_nettype wire

/* tests/rdma_framer_props.sv */
/*
   Output stream properties
   Bound to the framer top level, checks beat stability under stall,
   tkeep shape, a quiet output until the first packet is in
   and the input ready levels just after reset
*/
`timescale 1ns/100ps
`default_nettype none

module rdma_framer_props
   import stream_pkg::*;
(
   input wire logic                  clk,
   input wire logic                  resetn,
   input wire logic                  s_data_tvalid,
   input wire logic                  s_data_tlast,
   input wire logic                  s_data_tready,
   input wire logic                  s_rdma_tready,
   input wire logic [DATA_WIDTH-1:0] m_tx_tdata,
   input wire logic [STREAM_WB-1:0]  m_tx_tkeep,
   input wire logic                  m_tx_tvalid,
   input wire logic                  m_tx_tlast,
   input wire logic                  m_tx_tready
);

   int   fail_count = 0;
   // A whole input packet has been accepted since reset
   logic pkt_in_seen;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         pkt_in_seen <= 1'b0;
      end else if (s_data_tvalid && s_data_tready && s_data_tlast) begin
         pkt_in_seen <= 1'b1;
      end
   end

   // Stalled beat holds valid, data, keep and last
   hold_while_stalled: assert property (@(posedge clk) disable iff (!resetn)
      m_tx_tvalid && !m_tx_tready |=> m_tx_tvalid && $stable(m_tx_tdata)
         && $stable(m_tx_tkeep) && $stable(m_tx_tlast))
   else begin
      fail_count++;
      $error("output beat changed while stalled");
   end

   // Kept lanes start at lane 0 and are contiguous
   keep_contiguous: assert property (@(posedge clk) disable iff (!resetn)
      m_tx_tvalid |-> m_tx_tkeep[0] && ((m_tx_tkeep & (m_tx_tkeep + 1'b1)) == '0))
   else begin
      fail_count++;
      $error("output tkeep not contiguous from lane 0");
   end

   // No header beat before a packet and its length are in
   quiet_until_first_packet: assert property (@(posedge clk) disable iff (!resetn)
      !pkt_in_seen |-> !m_tx_tvalid)
   else begin
      fail_count++;
      $error("output valid raised before any packet was received");
   end

   // FIFOs hold input ready low one cycle out of reset, then open up
   ready_after_reset: assert property (@(posedge clk)
      $rose(resetn) |-> (!s_data_tready && !s_rdma_tready)
         ##1 (s_data_tready && s_rdma_tready))
   else begin
      fail_count++;
      $error("input ready wrong just after reset");
   end

endmodule

bind rdma_framer_top rdma_framer_props props (
   .clk           (clk),
   .resetn        (resetn),
   .s_data_tvalid (s_data_tvalid),
   .s_data_tlast  (s_data_tlast),
   .s_data_tready (s_data_tready),
   .s_rdma_tready (s_rdma_tready),
   .m_tx_tdata    (m_tx_tdata),
   .m_tx_tkeep    (m_tx_tkeep),
   .m_tx_tvalid   (m_tx_tvalid),
   .m_tx_tlast    (m_tx_tlast),
   .m_tx_tready   (m_tx_tready)
);

`default_nettype wire

/* tests/tb_clock_gen.sv */
/*
   Testbench clock and reset
   10 ns clock, active-low reset held for the first 8 cycles
*/
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic resetn
);

   // Free-running clock
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      resetn = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;
   end

endmodule

`default_nettype wire

/* tests/tb_checker.sv */
/*
   Output checker
   Compares each framed output beat with the expected header or payload beat
   and counts mismatches and framing errors
*/
`timescale 1ns/100ps
`default_nettype none

module tb_checker
   import stream_pkg::*;
   import net_hdr_pkg::*;
(
   input wire logic                  clk,
   input wire logic                  resetn,
   input wire logic [DATA_WIDTH-1:0] tdata,
   input wire logic [STREAM_WB-1:0]  tkeep,
   input wire logic                  tvalid,
   input wire logic                  tlast,
   input wire logic                  tready
);

   // Filled by the stimulus, one entry per packet or per payload beat
   int                    exp_len_q   [$];
   logic [63:0]           exp_addr_q  [$];
   logic [7:0]            exp_burst_q [$];
   logic [DATA_WIDTH-1:0] exp_data_q  [$];
   logic [STREAM_WB-1:0]  exp_keep_q  [$];
   logic                  exp_last_q  [$];

   int   mismatch_count = 0;
   int   other_count    = 0;
   int   pkts_done      = 0;
   // Header seen, payload beats follow
   logic in_packet      = 1'b0;

   // Ones-complement rule over the ten IPv4 words, checksum word as zero
   function automatic logic [15:0] ip_checksum(input int len);
      logic [15:0] words [10];
      logic [31:0] sum;
      logic [15:0] folded;
      words = '{IP_VER_DSF, 16'(37 + len), IP_ID, IP_FLAGS, IP_TTL_PROT, 16'h0000,
                IP_SRC_HI, IP_SRC_LO, IP_DST_HI, IP_DST_LO};
      sum = '0;
      foreach (words[i]) begin
         sum = sum + words[i];
      end
      folded = sum[15:0] + sum[31:16];
      return ~folded;
   endfunction

   // 25 network-order words plus burst length, first wire byte in lane 0
   function automatic logic [DATA_WIDTH-1:0] expected_header(input int len,
         input logic [63:0] addr, input logic [7:0] burst);
      logic [15:0]           w [25];
      logic [DATA_WIDTH-1:0] beat;
      w = '{ETH_DST_MAC[47:32], ETH_DST_MAC[31:16], ETH_DST_MAC[15:0],
            ETH_SRC_MAC[47:32], ETH_SRC_MAC[31:16], ETH_SRC_MAC[15:0], ETH_FRAME_TYPE,
            IP_VER_DSF, 16'(37 + len), IP_ID, IP_FLAGS, IP_TTL_PROT, ip_checksum(len),
            IP_SRC_HI, IP_SRC_LO, IP_DST_HI, IP_DST_LO,
            UDP_SRC_PORT, UDP_DST_PORT, 16'(17 + len), UDP_CHECKSUM,
            addr[63:48], addr[47:32], addr[31:16], addr[15:0]};
      beat = '0;
      for (int k = 0; k < 25; k++) begin
         beat[(2*k)*8 +: 8]   = w[k][15:8];
         beat[(2*k+1)*8 +: 8] = w[k][7:0];
      end
      beat[50*8 +: 8] = burst;
      return beat;
   endfunction

   task automatic compare_field(input string name, input logic [DATA_WIDTH-1:0] got,
                                input logic [DATA_WIDTH-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got %0h expected %0h at %0t", name, got, exp, $time);
         mismatch_count++;
      end
   endtask

   task automatic check_header();
      int len;
      if (exp_len_q.size() == 0) begin
         $display("ERROR: header beat sent with no packet outstanding at %0t", $time);
         other_count++;
      end else begin
         len = exp_len_q.pop_front();
         // Length and checksum fields on their own, then the whole beat
         compare_field("ip_total_len", {tdata[16*8 +: 8], tdata[17*8 +: 8]}, 37 + len);
         compare_field("udp_len", {tdata[38*8 +: 8], tdata[39*8 +: 8]}, 17 + len);
         compare_field("ip_checksum", {tdata[24*8 +: 8], tdata[25*8 +: 8]}, ip_checksum(len));
         compare_field("hdr_tdata", tdata,
                       expected_header(len, exp_addr_q.pop_front(), exp_burst_q.pop_front()));
         compare_field("hdr_tkeep", tkeep,
                       {{(STREAM_WB-FULL_HDR_LEN){1'b0}}, {FULL_HDR_LEN{1'b1}}});
         compare_field("hdr_tlast", tlast, 1'b0);
         in_packet = 1'b1;
      end
   endtask

   task automatic check_payload();
      if (exp_data_q.size() == 0) begin
         $display("ERROR: payload beat sent with no beat outstanding at %0t", $time);
         other_count++;
      end else begin
         compare_field("tdata", tdata, exp_data_q.pop_front());
         compare_field("tkeep", tkeep, exp_keep_q.pop_front());
         compare_field("tlast", tlast, exp_last_q.pop_front());
      end
      if (tlast) begin
         in_packet = 1'b0;
         pkts_done++;
      end
   endtask

   // Accepted output beats only
   always @(posedge clk) begin
      if (resetn && tvalid && tready) begin
         if (!in_packet) begin
            check_header();
         end else begin
            check_payload();
         end
      end
   end

endmodule

`default_nettype wire

/* tests/tb_top.sv */
/*
   Testbench top for the RDMA framer
   Applies a packet table with random input gaps and random output
   back-pressure, hands the expected beats to the checker, reports the result
*/
`timescale 1ns/100ps
`default_nettype none

module tb_top
   import stream_pkg::*;
();

   localparam int NUM_PKTS        = 8;
   localparam int WATCHDOG_CYCLES = 200 * NUM_PKTS + 100;

   // ==============================
   // Packet table
   // ==============================
   localparam int          LEN_TBL   [NUM_PKTS] = '{1, 64, 65, 600, 127, 200, 13, 512};
   localparam logic [63:0] ADDR_TBL  [NUM_PKTS] = '{
      64'h0000_0000_0000_1000, 64'h0123_4567_89AB_CDEF, 64'hFFFF_FFFF_FFFF_FFC0,
      64'h8000_0000_0000_0001, 64'h0000_00FF_0000_FF00, 64'hA5A5_5A5A_A5A5_5A5A,
      64'h0000_0000_0000_0000, 64'h7654_3210_FEDC_BA98
   };
   localparam logic [7:0]  BURST_TBL [NUM_PKTS] = '{
      8'h01, 8'h10, 8'h11, 8'hFF, 8'h02, 8'h80, 8'h00, 8'h40
   };

   logic                      clk;
   logic                      resetn;
   logic [DATA_WIDTH-1:0]     s_data_tdata;
   logic [STREAM_WB-1:0]      s_data_tkeep;
   logic                      s_data_tvalid;
   logic                      s_data_tlast;
   logic                      s_data_tready;
   logic [RDMA_HDR_LEN*8-1:0] s_rdma_tdata;
   logic                      s_rdma_tvalid;
   logic                      s_rdma_tready;
   logic [DATA_WIDTH-1:0]     m_tx_tdata;
   logic [STREAM_WB-1:0]      m_tx_tkeep;
   logic                      m_tx_tvalid;
   logic                      m_tx_tlast;
   logic                      m_tx_tready;

   integer seed = 32'hfbff76f4;
   int     leftover_errors = 0;

   tb_clock_gen clocks (.clk(clk), .resetn(resetn));

   rdma_framer_top uut (
      .clk           (clk),
      .resetn        (resetn),
      .s_data_tdata  (s_data_tdata),
      .s_data_tkeep  (s_data_tkeep),
      .s_data_tvalid (s_data_tvalid),
      .s_data_tlast  (s_data_tlast),
      .s_data_tready (s_data_tready),
      .s_rdma_tdata  (s_rdma_tdata),
      .s_rdma_tvalid (s_rdma_tvalid),
      .s_rdma_tready (s_rdma_tready),
      .m_tx_tdata    (m_tx_tdata),
      .m_tx_tkeep    (m_tx_tkeep),
      .m_tx_tvalid   (m_tx_tvalid),
      .m_tx_tlast    (m_tx_tlast),
      .m_tx_tready   (m_tx_tready)
   );

   tb_checker check (
      .clk    (clk),
      .resetn (resetn),
      .tdata  (m_tx_tdata),
      .tkeep  (m_tx_tkeep),
      .tvalid (m_tx_tvalid),
      .tlast  (m_tx_tlast),
      .tready (m_tx_tready)
   );

   // Next falling edge, output ready high about three cycles in four
   task automatic next_cycle();
      @(negedge clk);
      m_tx_tready = (($random(seed) & 3) != 0);
   endtask

   // One RDMA header word, held until accepted
   task automatic send_rdma(input logic [RDMA_HDR_LEN*8-1:0] word);
      s_rdma_tdata  = word;
      s_rdma_tvalid = 1'b1;
      #1;
      while (!s_rdma_tready) begin
         next_cycle();
         #1;
      end
      next_cycle();
      s_rdma_tvalid = 1'b0;
   endtask

   // One data beat after a random gap, held until accepted
   task automatic send_beat(input logic [DATA_WIDTH-1:0] d, input logic [STREAM_WB-1:0] k,
                            input logic l);
      while (($random(seed) & 3) == 0) begin
         next_cycle();
      end
      s_data_tdata  = d;
      s_data_tkeep  = k;
      s_data_tlast  = l;
      s_data_tvalid = 1'b1;
      #1;
      while (!s_data_tready) begin
         next_cycle();
         #1;
      end
      next_cycle();
      s_data_tvalid = 1'b0;
   endtask

   // Header word, then the payload split into beats with random bytes
   task automatic send_packet(input int idx);
      int                    len;
      int                    nbeats;
      int                    pos;
      logic [31:0]           rnd;
      logic [DATA_WIDTH-1:0] d;
      logic [STREAM_WB-1:0]  k;
      len    = LEN_TBL[idx];
      nbeats = (len + STREAM_WB - 1) / STREAM_WB;
      check.exp_len_q.push_back(len);
      check.exp_addr_q.push_back(ADDR_TBL[idx]);
      check.exp_burst_q.push_back(BURST_TBL[idx]);
      // Raw word is burst length above target address
      send_rdma({BURST_TBL[idx], ADDR_TBL[idx]});
      for (int b = 0; b < nbeats; b++) begin
         d = '0;
         k = '0;
         for (int i = 0; i < STREAM_WB; i++) begin
            pos = b * STREAM_WB + i;
            if (pos < len) begin
               rnd          = $random(seed);
               d[i*8 +: 8] = rnd[7:0];
               k[i]         = 1'b1;
            end
         end
         check.exp_data_q.push_back(d);
         check.exp_keep_q.push_back(k);
         check.exp_last_q.push_back(b == nbeats - 1);
         send_beat(d, k, b == nbeats - 1);
      end
   endtask

   // ==============================
   // Stimulus and result
   // ==============================
   initial begin
      s_data_tdata  = '0;
      s_data_tkeep  = '0;
      s_data_tvalid = 1'b0;
      s_data_tlast  = 1'b0;
      s_rdma_tdata  = '0;
      s_rdma_tvalid = 1'b0;
      m_tx_tready   = 1'b0;
      wait (resetn === 1'b1);
      next_cycle();
      for (int p = 0; p < NUM_PKTS; p++) begin
         send_packet(p);
      end
      // Drain, then watch a while for stray beats
      while (check.pkts_done < NUM_PKTS) begin
         next_cycle();
      end
      repeat (20) next_cycle();
      if (check.exp_data_q.size() != 0 || check.exp_len_q.size() != 0) begin
         $display("ERROR: expected beats or headers were never sent by the DUT");
         leftover_errors = 1;
      end
      $display("Errors: mismatch=%0d other=%0d assertion=%0d", check.mismatch_count,
               check.other_count + leftover_errors, uut.props.fail_count);
      if (check.mismatch_count + check.other_count + leftover_errors
          + uut.props.fail_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("ERROR: timeout after %0d cycles, %0d of %0d packets framed",
               WATCHDOG_CYCLES, check.pkts_done, NUM_PKTS);
      $display("Errors: mismatch=%0d other=%0d assertion=%0d", check.mismatch_count,
               check.other_count + 1, uut.props.fail_count);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
design/stream_pkg.sv
design/net_hdr_pkg.sv
design/axis_beat_if.sv
design/sync_fifo.sv
design/packet_length_meter.sv
design/udp_header_builder.sv
design/tx_sequencer.sv
design/rdma_framer_top.sv
tests/rdma_framer_props.sv
tests/tb_clock_gen.sv
tests/tb_checker.sv
tests/tb_top.sv

/* Bender.yml */
package:
  name: rdma_framer

sources:
  - design/stream_pkg.sv
  - design/net_hdr_pkg.sv
  - design/axis_beat_if.sv
  - design/sync_fifo.sv
  - design/packet_length_meter.sv
  - design/udp_header_builder.sv
  - design/tx_sequencer.sv
  - design/rdma_framer_top.sv
  - target: test
    files:
      - tests/rdma_framer_props.sv
      - tests/tb_clock_gen.sv
      - tests/tb_checker.sv
      - tests/tb_top.sv
